// ==== logic/add_sub_unit.sv ====
`timescale 1ns/10ps

/*
 * Add/subtract unit. A station feeds a one-cycle adder whose result register
 * is held until the write-back arbiter grants it.
 */
module add_sub_unit (
    input  logic clk,
    input  logic rst_n,

    input  logic push,
    input  ppc_core_pkg::rs_entry_t entry,
    output logic full,
    output ppc_core_pkg::slot_t free_slot,

    input  logic wb_valid,
    input  ppc_core_pkg::result_t wb,

    input  logic grant,
    output logic result_valid,
    output ppc_core_pkg::result_t result
);
    import ppc_core_pkg::*;

    logic issue;
    rs_entry_t op;

    reservation_station #(
        .DEPTH(RS_DEPTH),
        .BASE_TAG(ADD_SUB_BASE)
    ) station (
        .clk(clk),
        .rst_n(rst_n),
        .push(push),
        .entry(entry),
        .full(full),
        .free_slot(free_slot),
        .issue_ok(!result_valid || grant),
        .issue(issue),
        .issue_entry(op),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    always_ff @(posedge clk) begin
        if (!rst_n)
            result_valid <= 1'b0;
        else if (issue)
            result_valid <= 1'b1;
        else if (grant)
            result_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            result.tag <= op.tag;
            result.rt  <= op.rt;
            case (op.op)
                SUBF:    result.value <= op.b.value - op.a.value;
                NEG:     result.value <= -op.a.value;
                default: result.value <= op.a.value + op.b.value;
            endcase
        end
    end

endmodule

// ==== logic/dispatcher.sv ====
`timescale 1ns/10ps

/*
 * Zero-cycle dispatch. Sends a decoded operation to its unit's station,
 * gathers operands from the register file and renames the destination.
 */
module dispatcher (
    input  logic decode_valid,
    output logic decode_ready,
    input  ppc_core_pkg::decoded_t decode,

    input  logic [0:1] rs_full,
    input  ppc_core_pkg::slot_t [0:1] free_slot,

    output ppc_isa_pkg::reg_addr_t rd_addr_a,
    output ppc_isa_pkg::reg_addr_t rd_addr_b,
    input  ppc_core_pkg::operand_t rd_a,
    input  ppc_core_pkg::operand_t rd_b,

    output logic [0:1] push,
    output ppc_core_pkg::rs_entry_t entry,

    output logic rename_en,
    output ppc_isa_pkg::reg_addr_t rename_addr,
    output ppc_core_pkg::tag_t rename_tag
);
    import ppc_core_pkg::*;

    logic accept;
    tag_t base_tag;
    tag_t new_tag;

    assign decode_ready = !rs_full[decode.unit];
    assign accept = decode_valid && decode_ready;

    assign base_tag = decode.unit == LOGICAL ? tag_t'(LOGICAL_BASE) : tag_t'(ADD_SUB_BASE);
    assign new_tag = base_tag + tag_t'(free_slot[decode.unit]);

    assign rd_addr_a = decode.ra;
    assign rd_addr_b = decode.rb;

    assign push[0] = accept && decode.unit == ADD_SUB;
    assign push[1] = accept && decode.unit == LOGICAL;

    always_comb begin
        entry.op = decode.op;
        entry.rt = decode.rt;
        entry.tag = new_tag;
        entry.a = rd_a;
        entry.b = rd_b;
        // addi with RA=0 means a literal zero, not r0
        if (decode.ra_zero)
            entry.a = '{value: '0, valid: 1'b1, tag: '0};
        if (decode.use_imm)
            entry.b = '{value: decode.imm, valid: 1'b1, tag: '0};
    end

    assign rename_en = accept;
    assign rename_addr = decode.rt;
    assign rename_tag = new_tag;

endmodule

// ==== logic/gp_reg_file.sv ====
`timescale 1ns/10ps

/*
 * General purpose register file with renaming. Each register keeps its value,
 * a valid flag and the tag of the operation that will write it next.
 */
module gp_reg_file (
    input  logic clk,
    input  logic rst_n,

    input  ppc_isa_pkg::reg_addr_t rd_addr_a,
    input  ppc_isa_pkg::reg_addr_t rd_addr_b,
    output ppc_core_pkg::operand_t rd_a,
    output ppc_core_pkg::operand_t rd_b,

    input  logic rename_en,
    input  ppc_isa_pkg::reg_addr_t rename_addr,
    input  ppc_core_pkg::tag_t rename_tag,

    input  logic wb_valid,
    input  ppc_core_pkg::result_t wb
);
    import ppc_isa_pkg::*;
    import ppc_core_pkg::*;

    word_t value [0:31];
    logic [0:31] valid;
    tag_t pending [0:31];

    function automatic operand_t read_port(reg_addr_t addr);
        operand_t op;
        op.value = value[addr];
        op.valid = valid[addr];
        op.tag = pending[addr];
        // Forward a result that arrives in the same cycle
        if (!op.valid && wb_valid && wb.tag == op.tag) begin
            op.value = wb.value;
            op.valid = 1'b1;
        end
        return op;
    endfunction

    always_comb begin
        rd_a = read_port(rd_addr_a);
        rd_b = read_port(rd_addr_b);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value   <= '{default: '0};
            valid   <= '1;
            pending <= '{default: '0};
        end else begin
            // Stale results from an overwritten rename are dropped
            if (wb_valid && !valid[wb.rt] && pending[wb.rt] == wb.tag) begin
                value[wb.rt] <= wb.value;
                valid[wb.rt] <= 1'b1;
            end
            // Rename beats a write-back to the same register
            if (rename_en) begin
                valid[rename_addr]   <= 1'b0;
                pending[rename_addr] <= rename_tag;
            end
        end
    end

endmodule

// ==== logic/instr_decode.sv ====
`timescale 1ns/10ps

/*
 * Registered decode stage. Accepts instruction words over valid/ready and
 * presents the decoded operation to dispatch one cycle later.
 */
module instr_decode (
    input  logic clk,
    input  logic rst_n,

    input  logic instruction_valid,
    output logic instruction_ready,
    input  ppc_isa_pkg::word_t instruction,

    output logic decode_valid,
    input  logic decode_ready,
    output ppc_core_pkg::decoded_t decode
);
    import ppc_isa_pkg::*;
    import ppc_core_pkg::*;

    insn_t insn;
    decoded_t next_decode;
    logic supported;
    logic running;

    assign insn = instruction;
    // Held low until the first cycle after reset
    assign instruction_ready = running && (!decode_valid || decode_ready);

    always_comb begin
        next_decode = '0;
        supported = 1'b0;
        next_decode.rt = insn.d_form.rt;
        next_decode.ra = insn.d_form.ra;
        next_decode.rb = insn.x_form.rb;
        case (insn.d_form.opcd)
            OPCD_ADDI: begin
                supported = 1'b1;
                next_decode.op = ADD;
                next_decode.ra_zero = insn.d_form.ra == 5'd0;
                next_decode.imm = {{16{insn.d_form.si[0]}}, insn.d_form.si};
                next_decode.use_imm = 1'b1;
            end
            OPCD_ANDI, OPCD_ORI, OPCD_XORI: begin
                supported = 1'b1;
                if (insn.d_form.opcd == OPCD_ANDI)
                    next_decode.op = AND;
                else if (insn.d_form.opcd == OPCD_ORI)
                    next_decode.op = OR;
                else
                    next_decode.op = XOR;
                next_decode.unit = LOGICAL;
                // Logical forms write RA and read RS from the RT field
                next_decode.rt = insn.d_form.ra;
                next_decode.ra = insn.d_form.rt;
                next_decode.imm = {16'h0000, insn.d_form.si};
                next_decode.use_imm = 1'b1;
            end
            OPCD_X: begin
                supported = 1'b1;
                case (insn.x_form.xo)
                    XO_ADD:  next_decode.op = ADD;
                    XO_SUBF: next_decode.op = SUBF;
                    XO_NEG:  next_decode.op = NEG;
                    XO_AND:  next_decode.op = AND;
                    XO_OR:   next_decode.op = OR;
                    XO_XOR:  next_decode.op = XOR;
                    XO_NOR:  next_decode.op = NOR;
                    default: supported = 1'b0;
                endcase
                // neg has no second source, so operand B is a constant zero
                next_decode.use_imm = next_decode.op == NEG;
                if (next_decode.op inside {AND, OR, XOR, NOR}) begin
                    next_decode.unit = LOGICAL;
                    next_decode.rt = insn.x_form.ra;
                    next_decode.ra = insn.x_form.rt;
                end
            end
            default: supported = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running      <= 1'b0;
            decode_valid <= 1'b0;
        end else begin
            running <= 1'b1;
            // Unsupported words are consumed without producing an operation
            if (instruction_ready)
                decode_valid <= instruction_valid && supported;
        end
    end

    always_ff @(posedge clk) begin
        if (instruction_ready && instruction_valid)
            decode <= next_decode;
    end

endmodule

// ==== logic/logical_unit.sv ====
`timescale 1ns/10ps

/*
 * Logical unit for and, or, xor and nor. Same station and held result
 * register as the adder, with a bitwise stage in between.
 */
module logical_unit (
    input  logic clk,
    input  logic rst_n,

    input  logic push,
    input  ppc_core_pkg::rs_entry_t entry,
    output logic full,
    output ppc_core_pkg::slot_t free_slot,

    input  logic wb_valid,
    input  ppc_core_pkg::result_t wb,

    input  logic grant,
    output logic result_valid,
    output ppc_core_pkg::result_t result
);
    import ppc_core_pkg::*;

    logic issue;
    rs_entry_t op;

    reservation_station #(
        .DEPTH(RS_DEPTH),
        .BASE_TAG(LOGICAL_BASE)
    ) station (
        .clk(clk),
        .rst_n(rst_n),
        .push(push),
        .entry(entry),
        .full(full),
        .free_slot(free_slot),
        .issue_ok(!result_valid || grant),
        .issue(issue),
        .issue_entry(op),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    always_ff @(posedge clk) begin
        if (!rst_n)
            result_valid <= 1'b0;
        else if (issue)
            result_valid <= 1'b1;
        else if (grant)
            result_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            result.tag <= op.tag;
            result.rt  <= op.rt;
            case (op.op)
                OR:      result.value <= op.a.value | op.b.value;
                XOR:     result.value <= op.a.value ^ op.b.value;
                NOR:     result.value <= ~(op.a.value | op.b.value);
                default: result.value <= op.a.value & op.b.value;
            endcase
        end
    end

endmodule

// ==== logic/ppc_core.sv ====
`timescale 1ns/10ps

/*
 * Top level of the out-of-order fixed-point core. Instructions enter through
 * a valid/ready port and results leave on the write-back bus.
 */
module ppc_core (
    input  logic clk,
    input  logic rst_n,

    input  logic instruction_valid,
    output logic instruction_ready,
    input  ppc_isa_pkg::word_t instruction,

    output logic wb_valid,
    output ppc_core_pkg::result_t wb
);
    import ppc_isa_pkg::*;
    import ppc_core_pkg::*;

    logic decode_valid;
    logic decode_ready;
    decoded_t decode;

    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    operand_t rd_a;
    operand_t rd_b;

    logic rename_en;
    reg_addr_t rename_addr;
    tag_t rename_tag;

    // Index 0 is the add/subtract unit, index 1 the logical unit
    logic [0:1] push;
    logic [0:1] rs_full;
    slot_t [0:1] free_slot;
    rs_entry_t entry;

    logic [0:1] req_valid;
    logic [0:1] grant;
    result_t [0:1] req;

    instr_decode decode_inst (
        .clk(clk),
        .rst_n(rst_n),
        .instruction_valid(instruction_valid),
        .instruction_ready(instruction_ready),
        .instruction(instruction),
        .decode_valid(decode_valid),
        .decode_ready(decode_ready),
        .decode(decode)
    );

    dispatcher dispatcher_inst (
        .decode_valid(decode_valid),
        .decode_ready(decode_ready),
        .decode(decode),
        .rs_full(rs_full),
        .free_slot(free_slot),
        .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b),
        .rd_a(rd_a),
        .rd_b(rd_b),
        .push(push),
        .entry(entry),
        .rename_en(rename_en),
        .rename_addr(rename_addr),
        .rename_tag(rename_tag)
    );

    gp_reg_file gpr_inst (
        .clk(clk),
        .rst_n(rst_n),
        .rd_addr_a(rd_addr_a),
        .rd_addr_b(rd_addr_b),
        .rd_a(rd_a),
        .rd_b(rd_b),
        .rename_en(rename_en),
        .rename_addr(rename_addr),
        .rename_tag(rename_tag),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    add_sub_unit add_sub_inst (
        .clk(clk),
        .rst_n(rst_n),
        .push(push[0]),
        .entry(entry),
        .full(rs_full[0]),
        .free_slot(free_slot[0]),
        .wb_valid(wb_valid),
        .wb(wb),
        .grant(grant[0]),
        .result_valid(req_valid[0]),
        .result(req[0])
    );

    logical_unit logical_inst (
        .clk(clk),
        .rst_n(rst_n),
        .push(push[1]),
        .entry(entry),
        .full(rs_full[1]),
        .free_slot(free_slot[1]),
        .wb_valid(wb_valid),
        .wb(wb),
        .grant(grant[1]),
        .result_valid(req_valid[1]),
        .result(req[1])
    );

    write_back_arbiter arbiter_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req_valid(req_valid),
        .req(req),
        .grant(grant),
        .wb_valid(wb_valid),
        .wb(wb)
    );

endmodule

// ==== logic/ppc_core_pkg.sv ====
/*
 * Microarchitecture definitions shared by the core modules: result tags,
 * station sizing and the records passed between decode, dispatch and units.
 */
package ppc_core_pkg;

    localparam int TAG_WIDTH    = 3;
    localparam int RS_DEPTH     = 4;
    localparam int SLOT_WIDTH   = $clog2(RS_DEPTH);
    localparam int ADD_SUB_BASE = 0;
    localparam int LOGICAL_BASE = 4;

    typedef logic [0:TAG_WIDTH-1] tag_t;
    typedef logic [0:SLOT_WIDTH-1] slot_t;

    typedef enum logic [2:0] {ADD, SUBF, NEG, AND, OR, XOR, NOR} fx_op_t;
    typedef enum logic {ADD_SUB, LOGICAL} unit_sel_t;

    // Value when valid, otherwise the tag of the pending writer
    typedef struct packed {
        ppc_isa_pkg::word_t value;
        logic               valid;
        tag_t               tag;
    } operand_t;

    typedef struct packed {
        fx_op_t                 op;
        unit_sel_t              unit;
        ppc_isa_pkg::reg_addr_t rt;
        ppc_isa_pkg::reg_addr_t ra;
        ppc_isa_pkg::reg_addr_t rb;
        logic                   ra_zero;
        ppc_isa_pkg::word_t     imm;
        logic                   use_imm;
    } decoded_t;

    typedef struct packed {
        fx_op_t                 op;
        ppc_isa_pkg::reg_addr_t rt;
        operand_t               a;
        operand_t               b;
        tag_t                   tag;
    } rs_entry_t;

    typedef struct packed {
        tag_t                   tag;
        ppc_isa_pkg::reg_addr_t rt;
        ppc_isa_pkg::word_t     value;
    } result_t;

endpackage

// ==== logic/ppc_isa_pkg.sv ====
/*
 * Architectural definitions of the supported fixed-point subset: instruction
 * formats, primary and extended opcodes, register numbers and data words.
 */
package ppc_isa_pkg;

    typedef logic [0:31] word_t;
    typedef logic [0:4] reg_addr_t;

    typedef struct packed {
        logic [0:5]  opcd;
        reg_addr_t   rt;
        reg_addr_t   ra;
        logic [0:15] si;
    } d_form_t;

    typedef struct packed {
        logic [0:5] opcd;
        reg_addr_t  rt;
        reg_addr_t  ra;
        reg_addr_t  rb;
        logic [0:9] xo;
        logic       rc;
    } x_form_t;

    // Same word, read by format
    typedef union packed {
        d_form_t d_form;
        x_form_t x_form;
    } insn_t;

    localparam logic [0:5] OPCD_ADDI = 6'd14;
    localparam logic [0:5] OPCD_ANDI = 6'd28;
    localparam logic [0:5] OPCD_ORI  = 6'd24;
    localparam logic [0:5] OPCD_XORI = 6'd26;
    localparam logic [0:5] OPCD_X    = 6'd31;

    localparam logic [0:9] XO_ADD  = 10'd266;
    localparam logic [0:9] XO_SUBF = 10'd40;
    localparam logic [0:9] XO_NEG  = 10'd104;
    localparam logic [0:9] XO_AND  = 10'd28;
    localparam logic [0:9] XO_OR   = 10'd444;
    localparam logic [0:9] XO_XOR  = 10'd316;
    localparam logic [0:9] XO_NOR  = 10'd124;

endpackage

// ==== logic/reservation_station.sv ====
`timescale 1ns/10ps

/*
 * Reservation station for one execution unit. Entries collect their operands
 * from the write-back bus and issue lowest index first once both are known.
 */
module reservation_station #(
    parameter int DEPTH    = 4,
    parameter int BASE_TAG = 0
) (
    input  logic clk,
    input  logic rst_n,

    input  logic push,
    input  ppc_core_pkg::rs_entry_t entry,
    output logic full,
    output logic [0:$clog2(DEPTH)-1] free_slot,

    input  logic issue_ok,
    output logic issue,
    output ppc_core_pkg::rs_entry_t issue_entry,

    input  logic wb_valid,
    input  ppc_core_pkg::result_t wb
);
    import ppc_core_pkg::*;

    localparam int IDX_WIDTH = $clog2(DEPTH);

    rs_entry_t slots [0:DEPTH-1];
    logic [0:DEPTH-1] busy;
    logic [0:DEPTH-1] issued;
    logic [0:DEPTH-1] ready;
    logic [0:IDX_WIDTH-1] issue_idx;

    function automatic operand_t snoop(operand_t op);
        operand_t res;
        res = op;
        if (!op.valid && wb_valid && wb.tag == op.tag) begin
            res.value = wb.value;
            res.valid = 1'b1;
        end
        return res;
    endfunction

    // Downward scan leaves the lowest index selected
    always_comb begin
        free_slot = '0;
        issue_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            ready[i] = busy[i] && !issued[i] && slots[i].a.valid && slots[i].b.valid;
            if (!busy[i])
                free_slot = IDX_WIDTH'(i);
            if (ready[i])
                issue_idx = IDX_WIDTH'(i);
        end
    end

    assign full = &busy;
    assign issue = issue_ok && |ready;
    assign issue_entry = slots[issue_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= '0;
            issued <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                // Tag stays reserved until its own result is on the bus
                if (wb_valid && wb.tag == tag_t'(BASE_TAG + i))
                    busy[i] <= 1'b0;
                if (issue && issue_idx == IDX_WIDTH'(i))
                    issued[i] <= 1'b1;
                if (push && free_slot == IDX_WIDTH'(i)) begin
                    busy[i]   <= 1'b1;
                    issued[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (push && free_slot == IDX_WIDTH'(i)) begin
                slots[i]   <= entry;
                slots[i].a <= snoop(entry.a);
                slots[i].b <= snoop(entry.b);
            end else begin
                slots[i].a <= snoop(slots[i].a);
                slots[i].b <= snoop(slots[i].b);
            end
        end
    end

endmodule

// ==== logic/write_back_arbiter.sv ====
`timescale 1ns/10ps

/*
 * Picks one unit result per cycle and registers it onto the common
 * write-back bus. Priority flips whenever both units compete.
 */
module write_back_arbiter (
    input  logic clk,
    input  logic rst_n,

    input  logic [0:1] req_valid,
    input  ppc_core_pkg::result_t [0:1] req,
    output logic [0:1] grant,

    output logic wb_valid,
    output ppc_core_pkg::result_t wb
);
    // Requester favored on a tie
    logic prio;

    always_comb begin
        grant = 2'b00;
        if (req_valid[prio])
            grant[prio] = 1'b1;
        else if (req_valid[~prio])
            grant[~prio] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio     <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= |req_valid;
            if (&req_valid)
                prio <= ~prio;
        end
    end

    always_ff @(posedge clk) begin
        if (|req_valid)
            wb <= grant[1] ? req[1] : req[0];
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module ppc_core_tb -Mdir obj_dir -f sources.f

./obj_dir/Vppc_core_tb | tee sim.log

if grep -q "^Testbench passed$" sim.log; then
    echo "Simulation result: PASS"
    exit 0
else
    echo "Simulation result: FAIL"
    exit 1
fi

// ==== sim/ppc_core_tb.sv ====
`timescale 1ns/10ps

/*
 * Testbench for the out-of-order core. Feeds a table of instruction words
 * through the valid/ready port and matches every write-back on a scoreboard.
 */
module ppc_core_tb;
    import ppc_isa_pkg::*;
    import ppc_core_pkg::*;

    typedef struct packed {
        word_t     insn;
        logic      expect_wb;
        reg_addr_t rt;
        word_t     value;
    } row_t;

    logic clk = 1'b0;
    logic rst_n;
    logic instruction_valid;
    logic instruction_ready;
    word_t instruction;
    logic wb_valid;
    result_t wb;

    row_t table_q[$];
    row_t expected_q[$];
    logic table_ready = 1'b0;
    logic [31:0] lfsr = 32'h2c99;
    int check_count = 0;
    int error_count = 0;

    ppc_core ppc_core_inst (
        .clk(clk),
        .rst_n(rst_n),
        .instruction_valid(instruction_valid),
        .instruction_ready(instruction_ready),
        .instruction(instruction),
        .wb_valid(wb_valid),
        .wb(wb)
    );

    always #50 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic word_t encode_d(input logic [0:5] opcd, input int f_rt, input int f_ra,
                                       input logic [15:0] imm);
        insn_t w;
        w = '0;
        w.d_form.opcd = opcd;
        w.d_form.rt = reg_addr_t'(f_rt);
        w.d_form.ra = reg_addr_t'(f_ra);
        w.d_form.si = imm;
        return w;
    endfunction

    // Logical forms put the source in the RT field and the target in RA
    function automatic word_t encode_x(input int f_rt, input int f_ra, input int f_rb,
                                       input logic [0:9] xo);
        insn_t w;
        w = '0;
        w.x_form.opcd = OPCD_X;
        w.x_form.rt = reg_addr_t'(f_rt);
        w.x_form.ra = reg_addr_t'(f_ra);
        w.x_form.rb = reg_addr_t'(f_rb);
        w.x_form.xo = xo;
        return w;
    endfunction

    task automatic add_row(input word_t insn, input logic expect_wb, input int rt,
                           input word_t value);
        table_q.push_back('{insn: insn, expect_wb: expect_wb, rt: reg_addr_t'(rt), value: value});
    endtask

    task automatic build_table();
        // addi from zero and from a register
        add_row(encode_d(OPCD_ADDI, 1, 0, 16'h0064), 1'b1, 1, 32'h0000_0064);
        add_row(encode_d(OPCD_ADDI, 2, 0, 16'hfffb), 1'b1, 2, 32'hffff_fffb);
        add_row(encode_d(OPCD_ADDI, 3, 0, 16'h7fff), 1'b1, 3, 32'h0000_7fff);
        add_row(encode_d(OPCD_ADDI, 4, 0, 16'h8000), 1'b1, 4, 32'hffff_8000);
        add_row(encode_d(OPCD_ADDI, 5, 1, 16'h0017), 1'b1, 5, 32'h0000_007b);
        add_row(encode_d(OPCD_ADDI, 6, 2, 16'hfff6), 1'b1, 6, 32'hffff_fff1);
        // Dependent arithmetic with logical results in between
        add_row(encode_x(7, 1, 5, XO_ADD), 1'b1, 7, 32'h0000_00df);
        add_row(encode_d(OPCD_XORI, 3, 8, 16'h0f0f), 1'b1, 8, 32'h0000_70f0);
        add_row(encode_x(9, 7, 1, XO_SUBF), 1'b1, 9, 32'hffff_ff85);
        add_row(encode_x(10, 9, 0, XO_NEG), 1'b1, 10, 32'h0000_007b);
        add_row(encode_x(8, 11, 3, XO_AND), 1'b1, 11, 32'h0000_70f0);
        add_row(encode_x(12, 10, 11, XO_ADD), 1'b1, 12, 32'h0000_716b);
        add_row(encode_x(12, 12, 6, XO_SUBF), 1'b1, 12, 32'hffff_8e86);
        // Zero-extended immediates, then register forms
        add_row(encode_d(OPCD_ANDI, 2, 13, 16'hfff0), 1'b1, 13, 32'h0000_fff0);
        add_row(encode_d(OPCD_ORI, 4, 14, 16'h1234), 1'b1, 14, 32'hffff_9234);
        add_row(encode_d(OPCD_XORI, 2, 15, 16'h8001), 1'b1, 15, 32'hffff_7ffa);
        add_row(encode_x(13, 16, 3, XO_OR), 1'b1, 16, 32'h0000_ffff);
        add_row(encode_x(14, 17, 15, XO_XOR), 1'b1, 17, 32'h0000_edce);
        add_row(encode_x(13, 18, 4, XO_NOR), 1'b1, 18, 32'h0000_000f);
        add_row(encode_x(14, 19, 2, XO_AND), 1'b1, 19, 32'hffff_9230);
        // Burst deeper than one station, r20 and r22 written repeatedly
        add_row(encode_d(OPCD_ADDI, 20, 0, 16'h0001), 1'b1, 20, 32'h0000_0001);
        add_row(encode_d(OPCD_ADDI, 20, 20, 16'h0002), 1'b1, 20, 32'h0000_0003);
        add_row(encode_d(OPCD_ADDI, 20, 20, 16'h0003), 1'b1, 20, 32'h0000_0006);
        add_row(encode_d(OPCD_ADDI, 20, 20, 16'h0004), 1'b1, 20, 32'h0000_000a);
        add_row(encode_d(OPCD_ADDI, 20, 20, 16'h0005), 1'b1, 20, 32'h0000_000f);
        add_row(encode_d(OPCD_ADDI, 20, 20, 16'h0006), 1'b1, 20, 32'h0000_0015);
        add_row(encode_x(21, 20, 20, XO_ADD), 1'b1, 21, 32'h0000_002a);
        add_row(encode_d(OPCD_ADDI, 22, 0, 16'h0007), 1'b1, 22, 32'h0000_0007);
        add_row(encode_d(OPCD_ADDI, 22, 0, 16'h0008), 1'b1, 22, 32'h0000_0008);
        add_row(encode_d(OPCD_ADDI, 22, 0, 16'h0009), 1'b1, 22, 32'h0000_0009);
        add_row(encode_d(OPCD_ADDI, 22, 0, 16'h000a), 1'b1, 22, 32'h0000_000a);
        add_row(encode_x(22, 23, 22, XO_OR), 1'b1, 23, 32'h0000_000a);
        // mulli, mullw and cmpi are not implemented
        add_row(encode_d(6'd7, 24, 1, 16'h0005), 1'b0, 0, 32'h0000_0000);
        add_row(encode_x(24, 1, 5, 10'd235), 1'b0, 0, 32'h0000_0000);
        add_row(encode_d(OPCD_ADDI, 24, 21, 16'hfffe), 1'b1, 24, 32'h0000_0028);
        add_row(encode_d(6'd11, 0, 24, 16'h0028), 1'b0, 0, 32'h0000_0000);
        add_row(encode_x(24, 25, 24, XO_NOR), 1'b1, 25, 32'hffff_ffd7);
        add_row(encode_x(26, 25, 20, XO_SUBF), 1'b1, 26, 32'h0000_003e);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR %0t: %s, got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // Tags of a unit start at its base, one per station slot
    function automatic logic tag_in_unit(input tag_t tag, input word_t insn_word);
        insn_t w;
        int base;
        w = insn_word;
        base = ADD_SUB_BASE;
        if (w.d_form.opcd inside {OPCD_ANDI, OPCD_ORI, OPCD_XORI} ||
            (w.d_form.opcd == OPCD_X && w.x_form.xo inside {XO_AND, XO_OR, XO_XOR, XO_NOR}))
            base = LOGICAL_BASE;
        return int'(tag) >= base && int'(tag) < base + RS_DEPTH;
    endfunction

    // Completion order is free, so any pending match is accepted
    task automatic take_write_back(input tag_t tag, input reg_addr_t rt, input word_t value);
        int idx;
        idx = -1;
        for (int i = 0; i < expected_q.size() && idx < 0; i++) begin
            if (expected_q[i].rt == rt && expected_q[i].value == value &&
                tag_in_unit(tag, expected_q[i].insn))
                idx = i;
        end
        check_value(32'(idx >= 0), 32'd1,
                    $sformatf("unexpected write-back r%0d = %h tag %0d", rt, value, tag));
        if (idx >= 0)
            expected_q.delete(idx);
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            check_value(32'(wb_valid), 32'd0, "wb_valid during reset");
            check_value(32'(instruction_ready), 32'd0, "instruction_ready during reset");
        end else if (wb_valid)
            take_write_back(wb.tag, wb.rt, wb.value);
    end

    initial begin
        wait (table_ready);
        repeat (20 * table_q.size() + 50) @(posedge clk);
        $display("Timeout: run stopped with %0d expected write-backs still missing",
                 expected_q.size());
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic accepted;
        int wait_cycles;
        rst_n = 1'b0;
        instruction_valid = 1'b0;
        instruction = '0;
        build_table();
        table_ready = 1'b1;

        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_value(32'(wb_valid), 32'd0, "wb_valid in first cycle after reset");

        wait_cycles = 0;
        while (!instruction_ready && wait_cycles < 10) begin
            @(negedge clk);
            wait_cycles++;
        end
        check_value(32'(instruction_ready), 32'd1, "instruction_ready after reset");

        @(posedge clk);
        #1;
        foreach (table_q[i]) begin
            lfsr = lfsr_step(lfsr);
            if (!lfsr[0]) begin
                @(posedge clk);
                #1;
            end
            instruction_valid = 1'b1;
            instruction = table_q[i].insn;
            do begin
                @(negedge clk);
                accepted = instruction_ready;
                if (accepted && table_q[i].expect_wb)
                    expected_q.push_back(table_q[i]);
                @(posedge clk);
                #1;
            end while (!accepted);
            instruction_valid = 1'b0;
        end

        while (expected_q.size() != 0)
            @(negedge clk);
        // Quiet period to catch extra write-backs
        repeat (10) @(negedge clk);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== sources.f ====
logic/ppc_isa_pkg.sv
logic/ppc_core_pkg.sv
logic/instr_decode.sv
logic/dispatcher.sv
logic/gp_reg_file.sv
logic/reservation_station.sv
logic/add_sub_unit.sv
logic/logical_unit.sv
logic/write_back_arbiter.sv
logic/ppc_core.sv
sim/ppc_core_tb.sv
